//--- Bender.yml
package:
  name: fifo_demo

sources:
  # packages first, the display package uses the FIFO package
  - hw/fifo_pkg.sv
  - hw/display_pkg.sv
  # design
  - hw/sequence_source.sv
  - hw/ff_fifo.sv
  - hw/fifo_display.sv
  - hw/fifo_demo_top.sv
  # testbench
  - target: test
    files:
      - verification/fifo_demo_tb.sv

//--- build.f
hw/fifo_pkg.sv
hw/display_pkg.sv
hw/sequence_source.sv
hw/ff_fifo.sv
hw/fifo_display.sv
hw/fifo_demo_top.sv
verification/fifo_demo_tb.sv

//--- hw/display_pkg.sv
// display package: segment pattern type, hex font and special segment codes

package display_pkg;

    // segments a..g on bits 7..1, dot on bit 0, all active high
    typedef logic [7:0] segment_t;

    // ----------------------------------------------------------------------
    // special codes
    // ----------------------------------------------------------------------

    // dash for a slot that holds no valid entry
    localparam segment_t seg_empty_entry = 8'b0000_0010;

    // decimal point alone, or-ed onto a digit
    localparam segment_t seg_dot = 8'b0000_0001;

    // ----------------------------------------------------------------------
    // hex font
    // ----------------------------------------------------------------------

    // the dot bit is always clear here
    function automatic segment_t hex_font(input fifo_pkg::fifo_data_t value);
        case (value)
            4'h0:    return 8'b1111_1100;
            4'h1:    return 8'b0110_0000;
            4'h2:    return 8'b1101_1010;
            4'h3:    return 8'b1111_0010;
            4'h4:    return 8'b0110_0110;
            4'h5:    return 8'b1011_0110;
            4'h6:    return 8'b1011_1110;
            4'h7:    return 8'b1110_0000;
            4'h8:    return 8'b1111_1110;
            4'h9:    return 8'b1111_0110;
            4'ha:    return 8'b1110_1110;
            4'hb:    return 8'b0011_1110;
            4'hc:    return 8'b1001_1100;
            4'hd:    return 8'b0111_1010;
            4'he:    return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

endpackage

//--- hw/ff_fifo.sv
// flip-flop FIFO with registered empty/full flags and a per-slot debug view

module ff_fifo
#(
    parameter int depth = 8
)
(
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               push,
    input  logic                               pop,
    input  fifo_pkg::fifo_data_t               write_data,
    output fifo_pkg::fifo_data_t               read_data,
    output fifo_pkg::fifo_status_t             status,
    output logic [depth - 1:0]                 debug_valid,
    output fifo_pkg::fifo_data_t [depth - 1:0] debug_data,
    output logic [$clog2(depth) - 1:0]         wr_ptr,
    output logic [$clog2(depth) - 1:0]         rd_ptr
);

    // depth is a power of two, so the pointers wrap by overflow
    localparam int ptr_w = $clog2(depth);

    typedef logic [ptr_w - 1:0] ptr_t;

    fifo_pkg::fifo_data_t [depth - 1:0] slot_data;
    logic [depth - 1:0]                 slot_valid;

    ptr_t wr_ptr_q;
    ptr_t rd_ptr_q;
    ptr_t wr_ptr_next;
    ptr_t rd_ptr_next;

    logic empty_q;
    logic full_q;

    assign wr_ptr_next = wr_ptr_q + ptr_t'(1);
    assign rd_ptr_next = rd_ptr_q + ptr_t'(1);

    // ----------------------------------------------------------------------
    // storage
    // ----------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (push)
            slot_data[wr_ptr_q] <= write_data;
    end

    // valid bits track which slots hold live data, for the display only
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            slot_valid <= '0;
        end
        else
        begin
            if (pop)
                slot_valid[rd_ptr_q] <= 1'b0;
            if (push)
                slot_valid[wr_ptr_q] <= 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // pointers and flags
    // ----------------------------------------------------------------------

    // flags are updated together with the pointers instead of being
    // derived from a pointer compare every cycle
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            empty_q  <= 1'b1;
            full_q   <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr_q <= wr_ptr_next;
            if (pop)
                rd_ptr_q <= rd_ptr_next;

            // push and pop together keep the fill level, flags stay
            if (push && !pop)
            begin
                empty_q <= 1'b0;
                full_q  <= (wr_ptr_next == rd_ptr_q);
            end
            else if (pop && !push)
            begin
                full_q  <= 1'b0;
                empty_q <= (rd_ptr_next == wr_ptr_q);
            end
        end
    end

    // ----------------------------------------------------------------------
    // outputs
    // ----------------------------------------------------------------------

    assign read_data    = slot_data[rd_ptr_q];
    assign status.empty = empty_q;
    assign status.full  = full_q;

    assign debug_valid  = slot_valid;
    assign debug_data   = slot_data;
    assign wr_ptr       = wr_ptr_q;
    assign rd_ptr       = rd_ptr_q;

endmodule

//--- hw/fifo_demo_top.sv
// FIFO demonstrator top level: producer, flip-flop FIFO and display consumer

module fifo_demo_top
#(
    parameter int depth    = 8,
    parameter int scan_div = 1024
)
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  push_key,
    input  logic                  pop_key,
    output logic [7:0]            led,
    output display_pkg::segment_t abcdefgh,
    output logic [depth - 1:0]    digit
);

    logic                               push;
    logic                               pop;
    fifo_pkg::fifo_data_t               write_data;
    fifo_pkg::fifo_data_t               read_data;
    fifo_pkg::fifo_data_t               popped;
    fifo_pkg::fifo_status_t             status;
    logic [depth - 1:0]                 debug_valid;
    fifo_pkg::fifo_data_t [depth - 1:0] debug_data;
    logic [$clog2(depth) - 1:0]         wr_ptr;
    logic [$clog2(depth) - 1:0]         rd_ptr;

    // ----------------------------------------------------------------------
    // producer, buffer, consumer
    // ----------------------------------------------------------------------

    sequence_source u_source
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .push_key   (push_key),
        .status     (status),
        .push       (push),
        .write_data (write_data)
    );

    ff_fifo #(.depth(depth)) u_fifo
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .push        (push),
        .pop         (pop),
        .write_data  (write_data),
        .read_data   (read_data),
        .status      (status),
        .debug_valid (debug_valid),
        .debug_data  (debug_data),
        .wr_ptr      (wr_ptr),
        .rd_ptr      (rd_ptr)
    );

    fifo_display #(.depth(depth), .scan_div(scan_div)) u_display
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .pop_key     (pop_key),
        .status      (status),
        .read_data   (read_data),
        .debug_valid (debug_valid),
        .debug_data  (debug_data),
        .wr_ptr      (wr_ptr),
        .rd_ptr      (rd_ptr),
        .pop         (pop),
        .popped      (popped),
        .abcdefgh    (abcdefgh),
        .digit       (digit)
    );

    // full on bit 7, empty on bit 6, last popped value on the low nibble
    assign led = {status.full, status.empty, 2'b00, popped};

endmodule

//--- hw/fifo_display.sv
// FIFO consumer: pops into the LED register and scans all slots onto the 7-segment display

module fifo_display
#(
    parameter int depth    = 8,
    parameter int scan_div = 1024
)
(
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               pop_key,
    input  fifo_pkg::fifo_status_t             status,
    input  fifo_pkg::fifo_data_t               read_data,
    input  logic [depth - 1:0]                 debug_valid,
    input  fifo_pkg::fifo_data_t [depth - 1:0] debug_data,
    input  logic [$clog2(depth) - 1:0]         wr_ptr,
    input  logic [$clog2(depth) - 1:0]         rd_ptr,
    output logic                               pop,
    output fifo_pkg::fifo_data_t               popped,
    output display_pkg::segment_t              abcdefgh,
    output logic [depth - 1:0]                 digit
);

    localparam int ptr_w = $clog2(depth);
    localparam int div_w = (scan_div > 1) ? $clog2(scan_div) : 1;

    typedef logic [ptr_w - 1:0] slot_t;
    typedef logic [div_w - 1:0] div_t;

    // ----------------------------------------------------------------------
    // pop side
    // ----------------------------------------------------------------------

    assign pop = pop_key & ~status.empty;

    // the head entry is captured at the popping edge
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            popped <= '0;
        else if (pop)
            popped <= read_data;
    end

    // ----------------------------------------------------------------------
    // scan divider and digit select
    // ----------------------------------------------------------------------

    div_t  div_cnt;
    slot_t scan_slot;
    logic  scan_step;

    assign scan_step = (div_cnt == div_t'(scan_div - 1));

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            div_cnt <= '0;
        else if (scan_step)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + div_t'(1);
    end

    // leftmost digit (top bit) shows slot 0, then the lit digit
    // moves right while the slot number counts up
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            digit     <= {1'b1, {(depth - 1){1'b0}}};
            scan_slot <= '0;
        end
        else if (scan_step)
        begin
            digit     <= {digit[0], digit[depth - 1:1]};
            scan_slot <= scan_slot + slot_t'(1);
        end
    end

    // ----------------------------------------------------------------------
    // segment pattern
    // ----------------------------------------------------------------------

    // dash for an empty slot, dot where either pointer sits
    always_comb
    begin
        if (debug_valid[scan_slot])
            abcdefgh = display_pkg::hex_font(debug_data[scan_slot]);
        else
            abcdefgh = display_pkg::seg_empty_entry;

        if (scan_slot == wr_ptr || scan_slot == rd_ptr)
            abcdefgh = abcdefgh | display_pkg::seg_dot;
    end

endmodule

//--- hw/fifo_pkg.sv
// fifo package: entry type, status flags and the producer's scrambled value table

package fifo_pkg;

    // ----------------------------------------------------------------------
    // entry type
    // ----------------------------------------------------------------------

    // one FIFO entry, also one hex digit on the display
    typedef logic [3:0] fifo_data_t;

    // ----------------------------------------------------------------------
    // status flags
    // ----------------------------------------------------------------------

    // both flags come from the buffer and are registered there
    typedef struct packed {
        logic empty;
        logic full;
    } fifo_status_t;

    // ----------------------------------------------------------------------
    // producer value table
    // ----------------------------------------------------------------------

    // scrambled sequence pushed by the producer, index 0 first
    // every value 0..f appears once, so the display shows distinct digits
    localparam fifo_data_t [0:15] value_table = '{
        4'h2,
        4'h6,
        4'hd,
        4'hb,
        4'h7,
        4'he,
        4'hc,
        4'h4,
        4'h1,
        4'h0,
        4'h9,
        4'ha,
        4'hf,
        4'h5,
        4'h8,
        4'h3
    };

endpackage

//--- hw/sequence_source.sv
// sequence source: gates the push key and feeds the scrambled table values in order

module sequence_source
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   push_key,
    input  fifo_pkg::fifo_status_t status,
    output logic                   push,
    output fifo_pkg::fifo_data_t   write_data
);

    // ----------------------------------------------------------------------
    // push gating
    // ----------------------------------------------------------------------

    // a key level held high simply repeats the push every cycle
    // while the FIFO has room
    assign push = push_key & ~status.full;

    // ----------------------------------------------------------------------
    // table index
    // ----------------------------------------------------------------------

    // points at the value the next accepted push will take
    logic [3:0] table_index;

    // refused pushes leave the index alone, so no table value is skipped
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            table_index <= '0;
        end
        else if (push)
        begin
            // wraps naturally after the sixteenth value
            table_index <= table_index + 4'd1;
        end
    end

    // ----------------------------------------------------------------------
    // value lookup
    // ----------------------------------------------------------------------

    // combinational from the index, valid in the same cycle as push
    assign write_data = fifo_pkg::value_table[table_index];

endmodule

//--- verification/fifo_demo_tb.sv
// fifo demo testbench: directed tests against a queue model, display decoder and watchdog

module fifo_demo_tb;

    localparam int depth        = 8;
    localparam int scan_div     = 4;
    localparam int clk_period   = 4;
    localparam int reset_cycles = 8;
    localparam int scan_cycles  = depth * scan_div;

    // cycles spent by each test, scans included
    localparam int reset_test_cycles   = scan_cycles;
    localparam int fill_test_cycles    = 12 + 2 * scan_cycles;
    localparam int pop_test_cycles     = depth + 1;
    localparam int pointer_test_cycles = 20 + 3 * scan_cycles;
    localparam int random_test_cycles  = 200 + scan_cycles;
    localparam int total_cycles        = reset_cycles + reset_test_cycles + fill_test_cycles
                                         + pop_test_cycles + pointer_test_cycles
                                         + random_test_cycles;
    localparam int watchdog_time       = 2 * total_cycles * clk_period;

    logic                  clk;
    logic                  arst_n;
    logic                  push_key;
    logic                  pop_key;
    logic [7:0]            led;
    display_pkg::segment_t abcdefgh;
    logic [depth - 1:0]    digit;

    // model: queue of live entries, read pointer, table position, last popped value
    fifo_pkg::fifo_data_t model_q[$];
    int                   model_rd;
    int                   table_idx;
    fifo_pkg::fifo_data_t exp_popped;
    int                   error_count;

    // clock edges since reset release, sets the expected scan position
    int                   cycle_count;

    // segments seen per slot during the last scan
    display_pkg::segment_t scan_seg[depth];

    fifo_demo_top #(.depth(depth), .scan_div(scan_div)) uut
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .push_key (push_key),
        .pop_key  (pop_key),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // checking and model helpers
    // ----------------------------------------------------------------------

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("[ERROR] %s: got 'h%0h, expected 'h%0h at %0t",
                     name, actual, expected, $time);
            error_count++;
        end
    endtask

    function automatic logic [7:0] expected_led();
        return {model_q.size() == depth, model_q.size() == 0, 2'b00, exp_popped};
    endfunction

    // slot content follows from the queue laid out from the read pointer on
    function automatic display_pkg::segment_t expected_segment(input int slot);
        int                    fill;
        int                    offset;
        int                    wr;
        display_pkg::segment_t seg;
        fill   = model_q.size();
        offset = (slot - model_rd + depth) % depth;
        wr     = (model_rd + fill) % depth;
        if (offset < fill)
            seg = display_pkg::hex_font(model_q[offset]);
        else
            seg = display_pkg::seg_empty_entry;
        if (slot == wr || slot == model_rd)
            seg = seg | display_pkg::seg_dot;
        return seg;
    endfunction

    // entered one time unit after a rising edge, returns at the same point
    task automatic step_cycle(input logic push_k, input logic pop_k);
        logic               do_push;
        logic               do_pop;
        logic [depth - 1:0] exp_digit;
        push_key = push_k;
        pop_key  = pop_k;
        do_push  = push_k && (model_q.size() < depth);
        do_pop   = pop_k && (model_q.size() > 0);
        @(posedge clk);
        cycle_count++;
        if (do_pop)
        begin
            exp_popped = model_q.pop_front();
            model_rd   = (model_rd + 1) % depth;
        end
        if (do_push)
        begin
            model_q.push_back(fifo_pkg::value_table[table_idx]);
            table_idx = (table_idx + 1) % 16;
        end
        #1;
        check_value("led", led, expected_led());
        // lit digit moves one place down every scan_div cycles
        exp_digit = '0;
        exp_digit[depth - 1 - (cycle_count / scan_div) % depth] = 1'b1;
        check_value("digit", digit, exp_digit);
    endtask

    // one full pass over all digits with both keys released
    task automatic scan_display();
        logic [depth - 1:0] seen;
        int                 lit;
        int                 slot;
        seen = '0;
        repeat (scan_cycles)
        begin
            step_cycle(1'b0, 1'b0);
            check_value("digit_onehot", $onehot(digit), 1);
            lit = -1;
            for (int k = 0; k < depth; k++)
            begin
                if (digit[k])
                    lit = k;
            end
            if (lit >= 0)
            begin
                slot           = depth - 1 - lit;
                seen[lit]      = 1'b1;
                scan_seg[slot] = abcdefgh;
                check_value($sformatf("abcdefgh[slot %0d]", slot), abcdefgh,
                            expected_segment(slot));
            end
        end
        if (seen != '1)
        begin
            $display("a scan did not light every digit, lit digits %b", seen);
            error_count++;
        end
    endtask

    // ----------------------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------------------

    task automatic reset_state_test();
        check_value("led", led, 8'h40);
        check_value("digit", digit, {1'b1, {(depth - 1){1'b0}}});
        scan_display();
    endtask

    task automatic fill_order_test();
        fifo_pkg::fifo_data_t  fill_values[depth];
        display_pkg::segment_t exp_seg;
        fill_values = '{4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4};
        repeat (10)
            step_cycle(1'b1, 1'b0);
        check_value("led[7]", led[7], 1'b1);
        scan_display();
        // full, so both pointers sit on slot 0
        for (int i = 0; i < depth; i++)
        begin
            exp_seg = display_pkg::hex_font(fill_values[i]);
            if (i == 0)
                exp_seg = exp_seg | display_pkg::seg_dot;
            check_value($sformatf("fill_order[%0d]", i), scan_seg[i], exp_seg);
        end
        step_cycle(1'b0, 1'b1);
        step_cycle(1'b1, 1'b0);
        scan_display();
        // refused pushes must not have consumed table values
        check_value("value after refusal", scan_seg[0], display_pkg::hex_font(4'h1));
    endtask

    task automatic pop_order_test();
        logic [7:0] held;
        while (model_q.size() > 0)
            step_cycle(1'b0, 1'b1);
        check_value("led[6]", led[6], 1'b1);
        held = led;
        step_cycle(1'b0, 1'b1);
        check_value("led after pop on empty", led, held);
    endtask

    task automatic pointer_view_test();
        repeat (5)
            step_cycle(1'b1, 1'b0);
        repeat (3)
            step_cycle(1'b0, 1'b1);
        scan_display();
        // write pointer wraps past the last slot here
        repeat (6)
            step_cycle(1'b1, 1'b0);
        scan_display();
        repeat (4)
            step_cycle(1'b0, 1'b1);
        repeat (2)
            step_cycle(1'b1, 1'b0);
        scan_display();
    endtask

    task automatic simultaneous_test();
        repeat (200)
            step_cycle(1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)));
        scan_display();
    endtask

    // ----------------------------------------------------------------------
    // run control
    // ----------------------------------------------------------------------

    initial
    begin
        #(watchdog_time);
        $display("timeout: the tests did not complete within %0d time units", watchdog_time);
        $display("Finished with errors");
        $finish;
    end

    initial
    begin
        arst_n      = 1'b0;
        push_key    = 1'b0;
        pop_key     = 1'b0;
        model_rd    = 0;
        table_idx   = 0;
        exp_popped  = '0;
        error_count = 0;
        cycle_count = 0;
        void'($urandom(32'h8c70));

        repeat (reset_cycles)
            @(posedge clk);
        #1;
        arst_n = 1'b1;

        reset_state_test();
        fill_order_test();
        pop_order_test();
        pointer_view_test();
        simultaneous_test();

        $display("error count: %0d", error_count);
        if (error_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule
